/* tb/alink_vectors.txt */
# Columns, all hex: op a b c. T test number; W adr data; R adr expect compare_mask;
# D adr expecting the default read; S result word; X frame_word timeout; N quiet cycles
T 1 0 0
R 04 00010000 ffffffff
R 0c 00000000 ffffffff
N 28 0 0
T 2 0 0
W 00 a5c30f02 0
X a5c30f02 40 0
R 0c 00000004 ffffffff
T 3 0 0
W 08 00000008 0
D 08 0 0
W 00 12345603 0
N 40 0 0
R 04 00010000 ffffffff
W 04 80000000 0
R 04 80010000 ffffffff
W 00 0badf003 0
X 0badf003 40 0
R 0c 0000000c ffffffff
T 4 0 0
S 5eed0002 0 0
R 04 80100000 ffffffff
R 10 5eed0002 ffffffff
R 0c 00000008 ffffffff
T 5 0 0
W 00 cafe0006 0
W 00 11110003 0
W 00 22220003 0
W 00 33330003 0
R 04 80010030 fffffffd
W 04 80000002 0
R 04 80010000 fffffffd
R 0c 00000000 ffffffff
N 80 0 0
T 6 0 0
D 00 0 0
D 14 0 0
D 3c 0 0

/* filelist.f */
+incdir+common
common/alink_pkg.sv
common/alink_fifo_if.sv
rtl/alink_fifo.sv
rtl/alink_slave.sv
alink_phy/alink_tx_serializer.sv
alink_phy/alink_rx_deserializer.sv
rtl/alink_top.sv
tb/alink_chk.sv
tb/tb_alink.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_alink
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --assert -j 0

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_alink.sv */
`timescale 1ns/1ps
`include "alink_defs.svh"

module tb_alink;
    import alink_pkg::*;

    localparam int    BUS_TIMEOUT = 20;
    localparam string VEC_FILE    = "tb/alink_vectors.txt";

    logic       clk;
    logic       rst;
    logic       wb_stb;
    logic       wb_we;
    logic [5:0] wb_adr;
    word_t      wb_dat_w;
    logic       wb_ack;
    word_t      wb_dat_r;
    logic       link_txen;
    logic       link_txd;
    logic       link_rxvld;
    logic       link_rxd;

    int   checks;
    int   errors;
    int   test_num;
    int   test_checks;
    int   test_errors;
    logic timed_out;

    alink_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .link_txen  (link_txen),
        .link_txd   (link_txd),
        .link_rxvld (link_rxvld),
        .link_rxd   (link_rxd)
    );

    // Protocol checker sits inside the DUT scope
    bind alink_top alink_chk u_chk (
        .clk       (clk),
        .rst       (rst),
        .wb_ack    (wb_ack),
        .link_txen (link_txen),
        .flush     (flush),
        .tx_push   (tx_fifo_if.push),
        .tx_full   (tx_fifo_if.full),
        .rx_push   (rx_fifo_if.push),
        .rx_full   (rx_fifo_if.full)
    );

    always #5 clk = ~clk;

    task automatic record_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_timeout(input string what, input int cycles);
        $display("Timed out after %0d cycles waiting for %s", cycles, what);
        timed_out = 1'b1;
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp,
                              input word_t cmp);
        checks++;
        test_checks++;
        assert ((got & cmp) === (exp & cmp)) else
            record_fail($sformatf("%s returned %08h, expected %08h", what, got, exp));
    endtask

    // Called and left at 1 ns after a rising edge
    task automatic bus_access(input logic we, input logic [5:0] adr, input word_t data,
                              output word_t rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < BUS_TIMEOUT);
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (wb_ack)
            rdata = wb_dat_r;
        else
            report_timeout("wb_ack", waited);
    endtask

    task automatic read_check(input logic [5:0] adr, input word_t exp, input word_t cmp);
        word_t got;
        bus_access(1'b0, adr, '0, got);
        if (!timed_out)
            check_word($sformatf("read of %02h", adr), got, exp, cmp);
    endtask

    task automatic send_result(input word_t word);
        int i;
        for (i = 31; i >= 0; i--) begin
            link_rxvld = 1'b1;
            link_rxd   = word[i];   // MSB first
            @(posedge clk);
            #1;
        end
        link_rxvld = 1'b0;
        link_rxd   = 1'b0;
        @(posedge clk);   // The word is pushed one cycle after its last bit
        #1;
    endtask

    task automatic capture_frame(input word_t exp, input int limit);
        word_t got;
        int    waited;
        int    i;
        logic  bad_len;
        waited  = 0;
        got     = '0;
        bad_len = 1'b0;
        @(negedge clk);
        while (!link_txen && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!link_txen) begin
            report_timeout("a link_txen frame", waited);
        end else begin
            for (i = 0; i < 32; i++) begin
                if (!link_txen)
                    bad_len = 1'b1;
                got = {got[30:0], link_txd};
                @(negedge clk);
            end
            if (link_txen)
                bad_len = 1'b1;   // Frame ran past 32 bits
            checks++;
            test_checks++;
            assert (!bad_len) else
                record_fail("link_txen frame was not 32 cycles long");
            check_word("link frame", got, exp, '1);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic expect_silence(input int window);
        int   i;
        logic seen;
        seen = 1'b0;
        for (i = 0; i < window; i++) begin
            @(negedge clk);
            if (link_txen)
                seen = 1'b1;
        end
        checks++;
        test_checks++;
        assert (!seen) else
            record_fail($sformatf("link_txen went high inside a %0d-cycle window", window));
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test();
        if (test_num > 0)
            $display("Test %0d finished: %0d checks, %0d failures",
                     test_num, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_vector(input byte op, input word_t a, input word_t b, input word_t c);
        word_t rdata;
        case (op)
            "T": begin
                finish_test();
                test_num = int'(a);
            end
            "W": bus_access(1'b1, a[5:0], b, rdata);
            "R": read_check(a[5:0], b, c);
            "D": read_check(a[5:0], `ALINK_RD_DEFAULT, '1);
            "S": send_result(a);
            "X": capture_frame(a, int'(b));
            "N": expect_silence(int'(a));
            default: begin
                $display("Unknown opcode %c in the vector file", op);
                errors++;
                test_errors++;
            end
        endcase
    endtask

    initial begin
        string line;
        int    fd;
        int    n;
        byte   op;
        word_t a;
        word_t b;
        word_t c;
        clk         = 1'b0;
        rst         = 1'b1;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        link_rxvld  = 1'b0;
        link_rxd    = 1'b0;
        checks      = 0;
        errors      = 0;
        test_num    = 0;
        test_checks = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    a  = '0;
                    b  = '0;
                    c  = '0;
                    n  = $sscanf(line, "%c %h %h %h", op, a, b, c);
                    run_vector(op, a, b, c);
                end
            end
            $fclose(fd);
        end
        finish_test();
        $display("Checks run: %0d, failures: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* tb/alink_chk.sv */
`timescale 1ns/1ps

module alink_chk (
    input logic clk,
    input logic rst,
    input logic wb_ack,
    input logic link_txen,
    input logic flush,
    input logic tx_push,
    input logic tx_full,
    input logic rx_push,
    input logic rx_full
);

    logic [6:0] run_len;   // Cycles that link_txen has been high in a row

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            run_len <= '0;
        else if (flush || !link_txen)
            run_len <= '0;
        else
            run_len <= run_len + 1'b1;
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for two cycles");

    // An aborted frame during flush is legal
    a_frame_end: assert property (@(posedge clk) disable iff (rst || flush)
        $fell(link_txen) |-> run_len == 7'd32)
        else $error("link_txen frame did not last 32 cycles");

    a_frame_max: assert property (@(posedge clk) disable iff (rst || flush)
        link_txen |-> run_len < 7'd32)
        else $error("link_txen frame ran longer than 32 cycles");

    a_tx_push: assert property (@(posedge clk) disable iff (rst) tx_push |-> !tx_full)
        else $error("push into a full transmit FIFO");

    a_rx_push: assert property (@(posedge clk) disable iff (rst) rx_push |-> !rx_full)
        else $error("push into a full receive FIFO");

endmodule

/* rtl/alink_top.sv */
`timescale 1ns/1ps
`include "alink_defs.svh"

module alink_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [5:0]        wb_adr,
    input  alink_pkg::word_t  wb_dat_w,
    output logic              wb_ack,
    output alink_pkg::word_t  wb_dat_r,
    output logic              link_txen,
    output logic              link_txd,
    input  logic              link_rxvld,
    input  logic              link_rxd
);
    import alink_pkg::*;

    mask_t     mask;
    logic      scan;
    logic      flush;
    busy_t     busy;
    logic      result_valid;
    chip_idx_t result_chip;

    alink_fifo_if #(.CNT_W($bits(tx_cnt_t))) tx_fifo_if ();
    alink_fifo_if #(.CNT_W($bits(rx_cnt_t))) rx_fifo_if ();

    // One flush clears both FIFOs
    assign tx_fifo_if.flush = flush;
    assign rx_fifo_if.flush = flush;

    alink_slave u_slave (
        .clk      (clk),
        .rst      (rst),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .tx_fifo  (tx_fifo_if.writer),
        .rx_fifo  (rx_fifo_if.reader),
        .mask     (mask),
        .scan     (scan),
        .flush    (flush),
        .busy     (busy)
    );

    alink_fifo #(.DEPTH(`ALINK_TX_DEPTH)) u_tx_fifo (
        .clk  (clk),
        .rst  (rst),
        .port (tx_fifo_if.fifo)
    );

    alink_fifo #(.DEPTH(`ALINK_RX_DEPTH)) u_rx_fifo (
        .clk  (clk),
        .rst  (rst),
        .port (rx_fifo_if.fifo)
    );

    alink_tx_serializer u_tx_ser (
        .clk          (clk),
        .rst          (rst),
        .fifo         (tx_fifo_if.reader),
        .mask         (mask),
        .scan         (scan),
        .flush        (flush),
        .result_valid (result_valid),
        .result_chip  (result_chip),
        .busy         (busy),
        .link_txen    (link_txen),
        .link_txd     (link_txd)
    );

    alink_rx_deserializer u_rx_des (
        .clk          (clk),
        .rst          (rst),
        .link_rxvld   (link_rxvld),
        .link_rxd     (link_rxd),
        .flush        (flush),
        .fifo         (rx_fifo_if.writer),
        .result_valid (result_valid),
        .result_chip  (result_chip)
    );

endmodule

/* alink_phy/alink_rx_deserializer.sv */
`timescale 1ns/1ps

module alink_rx_deserializer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  link_rxvld,
    input  logic                  link_rxd,
    input  logic                  flush,
    alink_fifo_if.writer          fifo,
    output logic                  result_valid,
    output alink_pkg::chip_idx_t  result_chip
);
    import alink_pkg::*;

    word_t      shreg;
    logic [4:0] bit_cnt;
    logic       done;

    always_ff @(posedge clk) begin
        if (link_rxvld)
            shreg <= {shreg[30:0], link_rxd};   // MSB arrives first
    end

    // The count wraps to zero on the 32nd bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
            done    <= 1'b0;
        end else if (flush) begin
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= link_rxvld & (bit_cnt == 5'd31);
            if (link_rxvld)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // A full word sits in the shift register for the cycle that done is high
    assign fifo.push    = done;
    assign fifo.din     = shreg;
    assign result_valid = done;
    assign result_chip  = shreg[4:0];

endmodule

/* alink_phy/alink_tx_serializer.sv */
`timescale 1ns/1ps

module alink_tx_serializer (
    input  logic                  clk,
    input  logic                  rst,
    alink_fifo_if.reader          fifo,
    input  alink_pkg::mask_t      mask,
    input  logic                  scan,
    input  logic                  flush,
    input  logic                  result_valid,
    input  alink_pkg::chip_idx_t  result_chip,
    output alink_pkg::busy_t      busy,
    output logic                  link_txen,
    output logic                  link_txd
);
    import alink_pkg::*;

    typedef enum logic {IDLE, SEND} state_t;

    state_t    state;
    word_t     shreg;
    logic [4:0] bit_cnt;
    chip_idx_t tx_chip;
    logic      blocked;
    logic      start;

    assign tx_chip  = fifo.dout[4:0];
    assign blocked  = mask[tx_chip] & ~scan;

    // The pop cycle doubles as the idle gap between frames
    assign fifo.pop = (state == IDLE) & ~fifo.empty & ~flush;
    assign start    = fifo.pop & ~blocked;   // A blocked word is just dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else if (flush) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else if (state == IDLE) begin
            bit_cnt <= '0;
            if (start)
                state <= SEND;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 5'd31)
                state <= IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            shreg <= fifo.dout;
        else if (state == SEND)
            shreg <= {shreg[30:0], 1'b0};   // MSB goes out first
    end

    assign link_txen = (state == SEND);
    assign link_txd  = link_txen & shreg[31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (result_valid)
                busy[result_chip] <= 1'b0;
            if (start)
                busy[tx_chip] <= 1'b1;   // Set wins over a clear on the same chip
        end
    end

endmodule

/* rtl/alink_slave.sv */
`timescale 1ns/1ps
`include "alink_defs.svh"

module alink_slave (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [5:0]         wb_adr,
    input  alink_pkg::word_t   wb_dat_w,
    output logic               wb_ack,
    output alink_pkg::word_t   wb_dat_r,
    alink_fifo_if.writer       tx_fifo,
    alink_fifo_if.reader       rx_fifo,
    output alink_pkg::mask_t   mask,
    output logic               scan,
    output logic               flush,
    input  alink_pkg::busy_t   busy
);
    import alink_pkg::*;

    logic    acc;
    logic    wr_tx;
    logic    wr_state;
    logic    wr_mask;
    logic    rd_state;
    logic    rd_busy;
    logic    rd_rx;
    status_t status;
    status_t wr_status;
    logic [`ALINK_FLUSH_LEN-1:0] flush_sr;

    // A new access starts only outside the ack cycle
    assign acc = wb_stb & ~wb_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= acc;
    end

    assign wr_tx    = acc &  wb_we & (wb_adr == `ALINK_ADR_TXFIFO);
    assign wr_state = acc &  wb_we & (wb_adr == `ALINK_ADR_STATE);
    assign wr_mask  = acc &  wb_we & (wb_adr == `ALINK_ADR_MASK);
    assign rd_state = acc & ~wb_we & (wb_adr == `ALINK_ADR_STATE);
    assign rd_busy  = acc & ~wb_we & (wb_adr == `ALINK_ADR_BUSY);
    assign rd_rx    = acc & ~wb_we & (wb_adr == `ALINK_ADR_RXFIFO);

    // The FIFO sees the push one edge after the bus samples it
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tx_fifo.push <= 1'b0;
        else
            tx_fifo.push <= wr_tx;
    end

    always_ff @(posedge clk) begin
        tx_fifo.din <= wb_dat_w;
    end

    assign rx_fifo.pop = rd_rx;   // Head word is captured on the same edge

    assign wr_status = status_t'(wb_dat_w);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan     <= 1'b0;
            flush_sr <= '0;
        end else if (wr_state) begin
            scan     <= wr_status.scan;
            flush_sr <= {{(`ALINK_FLUSH_LEN-1){1'b0}}, wr_status.flush};
        end else begin
            flush_sr <= flush_sr << 1;
        end
    end

    assign flush = |flush_sr;   // High for one cycle per shift register stage

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            mask <= '0;
        else if (wr_mask)
            mask <= wb_dat_w;
    end

    always_comb begin
        status          = '0;
        status.scan     = scan;
        status.rx_cnt   = rx_fifo.cnt;
        status.rx_empty = rx_fifo.empty;
        status.tx_cnt   = tx_fifo.cnt;
        status.flush    = flush;
        status.tx_full  = tx_fifo.full;
    end

    always_ff @(posedge clk) begin
        case (1'b1)
            rd_state: wb_dat_r <= status;
            rd_busy:  wb_dat_r <= busy;
            rd_rx:    wb_dat_r <= rx_fifo.dout;
            default:  wb_dat_r <= `ALINK_RD_DEFAULT;
        endcase
    end

endmodule

/* rtl/alink_fifo.sv */
`timescale 1ns/1ps

module alink_fifo #(
    parameter int DEPTH = 1024
) (
    input  logic      clk,
    input  logic      rst,
    alink_fifo_if.fifo port
);
    import alink_pkg::*;

    // DEPTH must be a power of two so the pointers wrap on their own
    localparam int ADDR_W = $clog2(DEPTH);

    word_t             mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              do_push;
    logic              do_pop;

    assign port.empty = (count == '0);
    assign port.full  = (count == (ADDR_W+1)'(DEPTH));
    assign port.cnt   = count;
    assign port.dout  = mem[rd_ptr];   // Show-ahead head word

    assign do_push = port.push & ~port.full & ~port.flush;
    assign do_pop  = port.pop & ~port.empty & ~port.flush;

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= port.din;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (port.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither leave the count alone
            endcase
        end
    end

endmodule

/* common/alink_fifo_if.sv */
`timescale 1ns/1ps

interface alink_fifo_if #(
    parameter int CNT_W = 11
) ();
    import alink_pkg::*;

    logic             push;
    word_t            din;
    logic             pop;
    word_t            dout;     // Head word that is valid while empty is low
    logic [CNT_W-1:0] cnt;
    logic             empty;
    logic             full;
    logic             flush;

    modport writer (
        output push, din,
        input  cnt, empty, full
    );

    modport reader (
        output pop,
        input  dout, cnt, empty, full
    );

    modport fifo (
        input  push, din, pop, flush,
        output dout, cnt, empty, full
    );

endinterface

/* common/alink_pkg.sv */
package alink_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  chip_idx_t;   // Taken from word bits 4:0
    typedef logic [31:0] busy_t;
    typedef logic [31:0] mask_t;       // A set bit blocks that chip
    typedef logic [10:0] tx_cnt_t;
    typedef logic [9:0]  rx_cnt_t;

    // Status register layout from bit 31 down
    typedef struct packed {
        logic       scan;
        logic       rsv0;
        rx_cnt_t    rx_cnt;
        logic [2:0] rsv1;
        logic       rx_empty;
        logic       rsv2;
        tx_cnt_t    tx_cnt;
        logic [1:0] rsv3;
        logic       flush;
        logic       tx_full;
    } status_t;

endpackage

/* common/alink_defs.svh */
`ifndef ALINK_DEFS_SVH
`define ALINK_DEFS_SVH

// Register map on the 6-bit bus address
`define ALINK_ADR_TXFIFO 6'h00
`define ALINK_ADR_STATE  6'h04
`define ALINK_ADR_MASK   6'h08
`define ALINK_ADR_BUSY   6'h0C
`define ALINK_ADR_RXFIFO 6'h10

`define ALINK_TX_DEPTH 1024
`define ALINK_RX_DEPTH 512

// Returned by reads that have no readable register behind them
`define ALINK_RD_DEFAULT 32'hdeaddead

`define ALINK_FLUSH_LEN 4

`endif
